// ==== power_manager.f ====
hw/pm_pkg.sv
hw/rail_sequencer.sv
hw/button_timer.sv
hw/fault_tracker.sv
hw/pm_wb_regs.sv
hw/power_fsm.sv
hw/power_manager.sv
verification/pm_checker.sv
verification/tb_power_manager.sv

// ==== Bender.yml ====
package:
  name: power_manager

sources:
  - files:
      - hw/pm_pkg.sv
      - hw/rail_sequencer.sv
      - hw/button_timer.sv
      - hw/fault_tracker.sv
      - hw/pm_wb_regs.sv
      - hw/power_fsm.sv
      - hw/power_manager.sv
  - target: test
    files:
      - verification/pm_checker.sv
      - verification/tb_power_manager.sv

// ==== verification/tb_power_manager.sv ====
`timescale 1ns/1ps

module tb_power_manager import pm_pkg::*; ();

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  wb_adr_t     wb_adr_i;
  wb_dat_t     wb_dat_i;
  wb_dat_t     wb_dat_o;
  logic        wb_ack_o;
  health_t     health_i;
  logic        unsafe_health_i;
  logic        cold_start_i;
  logic        dma_done_i;
  logic        chs_button_i;
  power_good_t power_good_i;
  logic        power_ok_o;
  cause_t      no_power_cause_o;
  logic        soft_reset_o;
  logic        crash_o;
  logic        chs_pending_o;
  rail_en_t    rail_en_o;
  logic        atx_load_res_off_o;
  int          errors;
  int          checks;
  int          bus_errors;
  int unsigned scenarios = 400;

  power_manager DUT (.*);

  pm_checker u_checker (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .rdata_i(wb_dat_o), .ack_i(wb_ack_o), .health_i, .unsafe_health_i, .cold_start_i,
    .dma_done_i, .chs_button_i, .power_good_i, .power_ok_i(power_ok_o),
    .cause_i(no_power_cause_o), .soft_reset_i(soft_reset_o), .crash_i(crash_o),
    .chs_pending_i(chs_pending_o), .rail_en_i(rail_en_o), .atx_off_i(atx_load_res_off_o),
    .errors_o(errors), .checks_o(checks)
  );

  always #5 wb_clk_i = ~wb_clk_i;

  // stb stays up until the slave acks
  task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat);
    int waited;
    waited = 0;
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    do begin
      @(posedge wb_clk_i);
      waited++;
    end while (!wb_ack_o && waited < 4);
    if (!wb_ack_o) begin
      bus_errors++;
      $display("Wishbone access to address %0d got no acknowledge by %0d ns", adr, $time);
    end
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic press_button(input int cycles);
    chs_button_i <= 1'b1;
    repeat (cycles) @(posedge wb_clk_i);
    chs_button_i <= 1'b0;
  endtask

  initial begin
    int unsigned seed;
    int          kind;
    wb_adr_t     adr;
    wb_dat_t     dat;
    seed            = $urandom(32'hb280);
    wb_clk_i        = 1'b0;
    wb_rst_i        = 1'b1;
    wb_cyc_i        = 1'b0;
    wb_stb_i        = 1'b0;
    wb_we_i         = 1'b0;
    wb_adr_i        = '0;
    wb_dat_i        = '0;
    health_i        = '1;
    unsafe_health_i = 1'b0;
    cold_start_i    = 1'b1; // first boot waits for software
    dma_done_i      = 1'b1;
    chs_button_i    = 1'b0;
    power_good_i    = '0;
    bus_errors      = 0;
    repeat (10) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    for (int n = 0; n < scenarios; n++) begin
      kind = $urandom_range(0, 9);
      if (kind <= 5) begin
        adr = wb_adr_t'($urandom_range(0, 9)); // 8 and 9 are unmapped
        if (adr == REG_WD_CONF)
          dat = $urandom_range(0, 1) ? 16'd0 : wb_dat_t'($urandom_range(1, 31));
        else
          dat = wb_dat_t'($urandom_range(0, 1));
        bus_access($urandom_range(0, 1), adr, dat);
      end else if (kind == 6) begin
        press_button(($urandom_range(0, 3) == 0) ? BUTTON_HOLD + 5 : $urandom_range(1, 8));
      end else if (kind == 7) begin
        unsafe_health_i <= 1'b1;
        repeat ($urandom_range(1, 3)) @(posedge wb_clk_i);
        unsafe_health_i <= 1'b0;
      end else if (kind == 8) begin
        health_i     <= ($urandom_range(0, 3) == 0) ? health_t'($urandom) : 8'hff;
        dma_done_i   <= $urandom_range(0, 7) != 0;
        power_good_i <= power_good_t'($urandom);
        cold_start_i <= $urandom_range(0, 1);
      end
      repeat ($urandom_range(1, 30)) @(posedge wb_clk_i);
    end
    repeat (20) @(posedge wb_clk_i);
    $display("checks: %0d, errors: %0d, bus timeouts: %0d", checks, errors, bus_errors);
    if (errors == 0 && bus_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // bounded by the longest power cycle per scenario
  initial begin
    int unsigned limit_ns;
    limit_ns = (scenarios * (POWER_DOWN_WAIT + NUM_RAILS * STEP_WAIT + POST_POWERUP_WAIT
                + BUTTON_HOLD) + 1000) * 10;
    #(limit_ns);
    $display("Timeout: stimulus did not finish within %0d ns", limit_ns);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== verification/pm_checker.sv ====
`timescale 1ns/1ps

module pm_checker import pm_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  wb_adr_t     wb_adr_i,
  input  wb_dat_t     wb_dat_i,
  input  wb_dat_t     rdata_i,
  input  logic        ack_i,
  input  health_t     health_i,
  input  logic        unsafe_health_i,
  input  logic        cold_start_i,
  input  logic        dma_done_i,
  input  logic        chs_button_i,
  input  power_good_t power_good_i,
  input  logic        power_ok_i,
  input  cause_t      cause_i,
  input  logic        soft_reset_i,
  input  logic        crash_i,
  input  logic        chs_pending_i,
  input  rail_en_t    rail_en_i,
  input  logic        atx_off_i,
  output int          errors_o,
  output int          checks_o
);

  power_state_t st;
  cause_t       cause;
  int           pd_cnt;
  int           post_cnt;
  int           crashes;
  int           wds;
  int           wd_tmr;
  int           btn;      // button hold length
  int           step;     // rails on
  int           dly;
  logic         first;
  logic         pend;
  logic         chs_pd;
  logic         ack;
  logic         exp_soft;
  logic         exp_crash;
  logic         started;
  wd_conf_t     conf;
  pm_cmd_t      cmd;      // strobes one cycle after the write

  initial begin
    errors_o = 0;
    checks_o = 0;
    started  = 1'b0;
  end

  task automatic power_off(input cause_t why);
    st    <= NO_POWER;
    cause <= why;
  endtask

  task automatic restart();
    st       <= POWERED_DOWN;
    pd_cnt   <= POWER_DOWN_WAIT;
    exp_soft <= 1'b1;
  endtask

  task automatic crash_event();
    exp_crash <= 1'b1;
    if (crashes >= MAX_CRASHES)
      power_off(CAUSE_CRASH);
    else
      restart();
  endtask

  always @(posedge wb_clk_i) begin
    logic strb;
    logic hold;
    logic run;
    logic ovf;
    logic req;
    logic acc;
    strb = btn == 1;
    hold = btn == BUTTON_HOLD;
    run  = st == POWERED_UP && conf != 0;
    ovf  = run && ((wd_tmr >> WD_SHIFT) == conf);
    req  = st inside {POWERING_UP, CHECK, POWERED_UP};
    acc  = wb_cyc_i && wb_stb_i && !ack;
    exp_soft  <= 1'b0;
    exp_crash <= 1'b0;
    chs_pd    <= 1'b0;
    cmd       <= '0;
    if (wb_rst_i) begin
      started  <= 1'b1;
      st       <= POWERED_DOWN;
      cause    <= CAUSE_COLD;
      pd_cnt   <= POWER_DOWN_WAIT;
      post_cnt <= 0;
      first    <= 1'b1;
      crashes  <= 0;
      wds      <= 0;
      wd_tmr   <= 0;
      btn      <= 0;
      step     <= 0;
      dly      <= 0;
      pend     <= 1'b0;
      ack      <= 1'b0;
      conf     <= '0;
      exp_soft <= 1'b1;
    end else begin
      case (st)
        POWERED_DOWN: begin
          if (hold) begin
            power_off(CAUSE_USER);
          end else if (pd_cnt != 0) begin
            pd_cnt <= pd_cnt - 1;
          end else if ((health_i & HEALTH_MASK) == HEALTH_MASK && dma_done_i) begin
            first <= 1'b0;
            if (cold_start_i && first)
              power_off(CAUSE_COLD);
            else
              st <= POWERING_UP;
          end
        end
        POWERING_UP: begin
          if (hold) begin
            power_off(CAUSE_USER);
          end else if (step == NUM_RAILS) begin
            st       <= CHECK;
            post_cnt <= POST_POWERUP_WAIT;
          end
        end
        CHECK: begin
          if (hold)
            power_off(CAUSE_USER);
          else if (post_cnt != 0)
            post_cnt <= post_cnt - 1;
          else if (unsafe_health_i)
            crash_event();
          else
            st <= POWERED_UP;
        end
        POWERED_UP: begin
          if (hold || chs_pd || cmd.powerdown) begin
            power_off(CAUSE_USER);
          end else if (unsafe_health_i) begin
            crash_event();
          end else if (ovf) begin
            if (wds == MAX_WD_OVERFLOWS)
              power_off(CAUSE_WD);
            else
              restart();
          end else if (cmd.reset) begin
            restart();
          end
        end
        default: begin
          if (strb || cmd.powerup)
            restart();
        end
      endcase
      if (cmd.crash_ack)
        crashes <= 0;
      else if (exp_crash && crashes != 7)
        crashes <= crashes + 1;
      if (cmd.wd_ack)
        wds <= 0;
      else if (ovf && wds != 7)
        wds <= wds + 1;
      wd_tmr <= (!run || ovf || cmd.wd_ack) ? 0 : wd_tmr + 1;
      if (st != POWERED_UP) begin
        pend <= 1'b0;
      end else if (pend && cmd.chs_ack) begin
        pend   <= 1'b0;
        chs_pd <= 1'b1;
      end else if (strb) begin
        pend <= 1'b1;
      end
      if (!chs_button_i)
        btn <= 0;
      else if (st == NO_POWER)
        btn <= (btn == 0) ? 1 : BUTTON_HOLD + 1; // only the press counts
      else if (btn != BUTTON_HOLD + 1)
        btn <= btn + 1;
      if ((req && step < NUM_RAILS) || (!req && step > 0)) begin
        dly <= (dly == STEP_WAIT - 1) ? 0 : dly + 1;
        if (dly == STEP_WAIT - 1)
          step <= req ? step + 1 : step - 1;
      end else begin
        dly <= 0;
      end
      ack <= acc;
      if (acc && wb_we_i) begin
        case (wb_adr_i)
          REG_POWERUP: cmd.powerup <= wb_dat_i != 0;
          REG_POWERDOWN: begin
            cmd.powerdown <= wb_dat_i != 0;
            cmd.reset     <= wb_dat_i == 0; // zero means soft reset
          end
          REG_CRASH:   cmd.crash_ack <= 1'b1;
          REG_WD:      cmd.wd_ack    <= 1'b1;
          REG_CHS:     cmd.chs_ack   <= 1'b1;
          REG_WD_CONF: conf          <= wb_dat_i[4:0];
          default: ;
        endcase
      end
    end
  end

  function automatic wb_dat_t expected_read(input wb_adr_t adr);
    wb_dat_t v;
    v = '0;
    case (adr)
      REG_STATE: begin
        v[2:0] = st;
        v[9:8] = cause;
      end
      REG_CRASH:   v[2:0] = crashes[2:0];
      REG_WD:      v[2:0] = wds[2:0];
      REG_CHS:     v[0]   = pend;
      REG_PG:      v[4:0] = power_good_i;
      REG_WD_CONF: v[4:0] = conf;
      default: ;
    endcase
    return v;
  endfunction

  task automatic compare_value(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
    checks_o++;
    if (got !== exp) begin
      errors_o++;
      $display("Error at %0d ns: %s expected %0h, actual %0h", $time, name, exp, got);
    end
  endtask

  // outputs settle between edges
  always @(negedge wb_clk_i) begin
    if (started) begin
      compare_value("wb_ack_o", ack, ack_i);
      if (ack)
        compare_value("wb_dat_o", expected_read(wb_adr_i), rdata_i);
      compare_value("power_ok_o", st == POWERED_UP, power_ok_i);
      compare_value("rail_en_o", rail_en_t'((1 << step) - 1), rail_en_i);
      compare_value("no_power_cause_o", cause, cause_i);
      compare_value("soft_reset_o", exp_soft, soft_reset_i);
      compare_value("crash_o", exp_crash, crash_i);
      compare_value("chs_pending_o", pend, chs_pending_i);
      compare_value("atx_load_res_off_o", st inside {POWERED_UP, NO_POWER}, atx_off_i);
      if (power_ok_i === 1'b1 && rail_en_i !== '1) begin
        errors_o++;
        $display("Power ok is high at %0d ns while a rail is still off", $time);
      end
    end
  end

endmodule

// ==== hw/power_manager.sv ====
`timescale 1ns/1ps

module power_manager import pm_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  wb_adr_t     wb_adr_i,
  input  wb_dat_t     wb_dat_i,
  output wb_dat_t     wb_dat_o,
  output logic        wb_ack_o,
  input  health_t     health_i,
  input  logic        unsafe_health_i,
  input  logic        cold_start_i,
  input  logic        dma_done_i,
  input  logic        chs_button_i,
  input  power_good_t power_good_i,
  output logic        power_ok_o,
  output cause_t      no_power_cause_o,
  output logic        soft_reset_o,
  output logic        crash_o,
  output logic        chs_pending_o,
  output rail_en_t    rail_en_o,
  output logic        atx_load_res_off_o
);

  pm_cmd_t      cmd;
  pm_status_t   status;
  power_state_t power_state;
  wd_conf_t     wd_conf;
  count_t       unacked_crashes;
  count_t       unacked_wd;
  logic         chs_strb;
  logic         chs_force;
  logic         chs_powerdown;
  logic         wd_overflow;
  logic         power_up_req;
  logic         up_done;

  assign status.power_state     = power_state;
  assign status.no_power_cause  = no_power_cause_o;
  assign status.unacked_crashes = unacked_crashes;
  assign status.unacked_wd      = unacked_wd;
  assign status.chs_pending     = chs_pending_o;

  power_fsm u_fsm (
    .wb_clk_i, .wb_rst_i, .cmd_i(cmd), .health_i, .unsafe_health_i, .cold_start_i,
    .dma_done_i, .chs_strb_i(chs_strb), .chs_force_i(chs_force),
    .chs_powerdown_i(chs_powerdown), .wd_overflow_i(wd_overflow),
    .unacked_crashes_i(unacked_crashes), .unacked_wd_i(unacked_wd), .up_done_i(up_done),
    .power_state_o(power_state), .no_power_cause_o, .power_up_req_o(power_up_req),
    .power_ok_o, .soft_reset_o, .crash_o, .atx_load_res_off_o
  );

  rail_sequencer u_rails (
    .wb_clk_i, .wb_rst_i, .power_up_req_i(power_up_req), .rail_en_o, .up_done_o(up_done)
  );

  button_timer u_button (
    .wb_clk_i, .wb_rst_i, .chs_button_i, .no_power_i(power_state == NO_POWER),
    .chs_strb_o(chs_strb), .chs_force_o(chs_force)
  );

  fault_tracker u_faults (
    .wb_clk_i, .wb_rst_i, .power_state_i(power_state), .crash_i(crash_o), .cmd_i(cmd),
    .wd_conf_i(wd_conf), .chs_strb_i(chs_strb), .wd_overflow_o(wd_overflow),
    .unacked_crashes_o(unacked_crashes), .unacked_wd_o(unacked_wd), .chs_pending_o,
    .chs_powerdown_o(chs_powerdown)
  );

  pm_wb_regs u_regs (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o,
    .wb_ack_o, .status_i(status), .power_good_i, .cmd_o(cmd), .wd_conf_o(wd_conf)
  );

endmodule

// ==== hw/power_fsm.sv ====
`timescale 1ns/1ps

module power_fsm import pm_pkg::*; (
  input  logic         wb_clk_i,
  input  logic         wb_rst_i,
  input  pm_cmd_t      cmd_i,
  input  health_t      health_i,
  input  logic         unsafe_health_i,
  input  logic         cold_start_i,
  input  logic         dma_done_i,
  input  logic         chs_strb_i,
  input  logic         chs_force_i,
  input  logic         chs_powerdown_i,
  input  logic         wd_overflow_i,
  input  count_t       unacked_crashes_i,
  input  count_t       unacked_wd_i,
  input  logic         up_done_i,
  output power_state_t power_state_o,
  output cause_t       no_power_cause_o,
  output logic         power_up_req_o,
  output logic         power_ok_o,
  output logic         soft_reset_o,
  output logic         crash_o,
  output logic         atx_load_res_off_o
);

  power_state_t state;
  pd_wait_t     pd_wait;
  post_wait_t   post_wait;
  logic         first_boot;
  logic         pre_check_ok;
  logic         user_down;

  assign pre_check_ok = ((health_i & HEALTH_MASK) == HEALTH_MASK) && dma_done_i;
  assign user_down    = chs_force_i || chs_powerdown_i || cmd_i.powerdown;

  assign power_state_o      = state;
  assign power_up_req_o     = state inside {POWERING_UP, CHECK, POWERED_UP};
  assign power_ok_o         = state == POWERED_UP;
  assign atx_load_res_off_o = state inside {POWERED_UP, NO_POWER};

  always_ff @(posedge wb_clk_i) begin
    crash_o      <= 1'b0; // both are one-cycle pulses
    soft_reset_o <= 1'b0;
    if (wb_rst_i) begin
      state            <= POWERED_DOWN;
      pd_wait          <= pd_wait_t'(POWER_DOWN_WAIT);
      post_wait        <= '0;
      first_boot       <= 1'b1;
      no_power_cause_o <= CAUSE_COLD;
      soft_reset_o     <= 1'b1;
    end else begin
      case (state)
        POWERED_DOWN: begin
          if (chs_force_i) begin
            state            <= NO_POWER;
            no_power_cause_o <= CAUSE_USER;
          end else if (pd_wait != '0) begin
            pd_wait <= pd_wait - 1'b1;
          end else if (pre_check_ok) begin
            first_boot <= 1'b0;
            if (cold_start_i && first_boot) begin // cold start waits for software
              state            <= NO_POWER;
              no_power_cause_o <= CAUSE_COLD;
            end else begin
              state <= POWERING_UP;
            end
          end
        end
        POWERING_UP: begin
          if (chs_force_i) begin
            state            <= NO_POWER;
            no_power_cause_o <= CAUSE_USER;
          end else if (up_done_i) begin
            state     <= CHECK;
            post_wait <= post_wait_t'(POST_POWERUP_WAIT);
          end
        end
        CHECK: begin
          if (chs_force_i) begin
            state            <= NO_POWER;
            no_power_cause_o <= CAUSE_USER;
          end else if (post_wait != '0) begin
            post_wait <= post_wait - 1'b1;
          end else if (unsafe_health_i) begin // failed post-check counts as a crash
            crash_o <= 1'b1;
            if (unacked_crashes_i >= MAX_CRASHES) begin
              state            <= NO_POWER;
              no_power_cause_o <= CAUSE_CRASH;
            end else begin
              state        <= POWERED_DOWN;
              pd_wait      <= pd_wait_t'(POWER_DOWN_WAIT);
              soft_reset_o <= 1'b1;
            end
          end else begin
            state <= POWERED_UP;
          end
        end
        POWERED_UP: begin
          if (user_down) begin // highest priority
            state            <= NO_POWER;
            no_power_cause_o <= CAUSE_USER;
          end else if (unsafe_health_i) begin
            crash_o <= 1'b1;
            if (unacked_crashes_i >= MAX_CRASHES) begin
              state            <= NO_POWER;
              no_power_cause_o <= CAUSE_CRASH;
            end else begin
              state        <= POWERED_DOWN;
              pd_wait      <= pd_wait_t'(POWER_DOWN_WAIT);
              soft_reset_o <= 1'b1;
            end
          end else if (wd_overflow_i) begin
            if (unacked_wd_i == MAX_WD_OVERFLOWS) begin
              state            <= NO_POWER;
              no_power_cause_o <= CAUSE_WD;
            end else begin
              state        <= POWERED_DOWN;
              pd_wait      <= pd_wait_t'(POWER_DOWN_WAIT);
              soft_reset_o <= 1'b1;
            end
          end else if (cmd_i.reset) begin // lowest priority
            state        <= POWERED_DOWN;
            pd_wait      <= pd_wait_t'(POWER_DOWN_WAIT);
            soft_reset_o <= 1'b1;
          end
        end
        NO_POWER: begin
          if (chs_strb_i || cmd_i.powerup) begin
            state        <= POWERED_DOWN;
            pd_wait      <= pd_wait_t'(POWER_DOWN_WAIT);
            soft_reset_o <= 1'b1;
          end
        end
        default: state <= POWERED_DOWN;
      endcase
    end
  end

endmodule

// ==== hw/pm_wb_regs.sv ====
`timescale 1ns/1ps

module pm_wb_regs import pm_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  wb_adr_t     wb_adr_i,
  input  wb_dat_t     wb_dat_i,
  output wb_dat_t     wb_dat_o,
  output logic        wb_ack_o,
  input  pm_status_t  status_i,
  input  power_good_t power_good_i,
  output pm_cmd_t     cmd_o,
  output wd_conf_t    wd_conf_o
);

  logic access;
  logic wr;

  assign access = wb_cyc_i && wb_stb_i && !wb_ack_o; // new cycle, ack not yet given
  assign wr     = access && wb_we_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o  <= 1'b0;
      cmd_o     <= '0;
      wd_conf_o <= '0; // watchdog off
    end else begin
      wb_ack_o <= access;
      cmd_o    <= '0;
      if (wr) begin
        case (wb_adr_i)
          REG_POWERUP:   cmd_o.powerup <= wb_dat_i != '0;
          REG_POWERDOWN: begin
            cmd_o.powerdown <= wb_dat_i != '0;
            cmd_o.reset     <= wb_dat_i == '0;
          end
          REG_CRASH:     cmd_o.crash_ack <= 1'b1;
          REG_WD:        cmd_o.wd_ack    <= 1'b1;
          REG_CHS:       cmd_o.chs_ack   <= 1'b1;
          REG_WD_CONF:   wd_conf_o       <= wd_dat_conf(wb_dat_i);
          default: ;
        endcase
      end
    end
  end

  function automatic wd_conf_t wd_dat_conf(input wb_dat_t dat);
    return dat[$bits(wd_conf_t)-1:0]; // upper bits ignored
  endfunction

  // master holds the address through the ack cycle
  always_comb begin
    wb_dat_o = '0;
    case (wb_adr_i)
      REG_STATE: begin
        wb_dat_o[2:0] = status_i.power_state;
        wb_dat_o[9:8] = status_i.no_power_cause;
      end
      REG_CRASH:   wb_dat_o[2:0] = status_i.unacked_crashes;
      REG_WD:      wb_dat_o[2:0] = status_i.unacked_wd;
      REG_CHS:     wb_dat_o[0]   = status_i.chs_pending;
      REG_PG:      wb_dat_o[4:0] = power_good_i;
      REG_WD_CONF: wb_dat_o[4:0] = wd_conf_o;
      default: ;
    endcase
  end

endmodule

// ==== hw/fault_tracker.sv ====
`timescale 1ns/1ps

module fault_tracker import pm_pkg::*; (
  input  logic         wb_clk_i,
  input  logic         wb_rst_i,
  input  power_state_t power_state_i,
  input  logic         crash_i,
  input  pm_cmd_t      cmd_i,
  input  wd_conf_t     wd_conf_i,
  input  logic         chs_strb_i,
  output logic         wd_overflow_o,
  output count_t       unacked_crashes_o,
  output count_t       unacked_wd_o,
  output logic         chs_pending_o,
  output logic         chs_powerdown_o
);

  wd_timer_t wd_timer;
  logic      wd_run;
  logic      powered_up;

  assign powered_up = power_state_i == POWERED_UP;
  assign wd_run     = powered_up && (wd_conf_i != '0);

  // the fsm sees the count from before this overflow
  assign wd_overflow_o = wd_run && (wd_timer[$bits(wd_timer_t)-1 -: $bits(wd_conf_t)] == wd_conf_i);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !wd_run || wd_overflow_o || cmd_i.wd_ack) begin
      wd_timer <= '0; // software kicks the watchdog by acknowledging
    end else begin
      wd_timer <= wd_timer + 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || cmd_i.wd_ack) begin
      unacked_wd_o <= '0;
    end else if (wd_overflow_o && unacked_wd_o != '1) begin
      unacked_wd_o <= unacked_wd_o + 1'b1; // saturates
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || cmd_i.crash_ack) begin
      unacked_crashes_o <= '0;
    end else if (crash_i && unacked_crashes_o != '1) begin
      unacked_crashes_o <= unacked_crashes_o + 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    chs_powerdown_o <= 1'b0;
    if (wb_rst_i || !powered_up) begin
      chs_pending_o <= 1'b0;
    end else if (chs_pending_o && cmd_i.chs_ack) begin
      chs_pending_o   <= 1'b0;
      chs_powerdown_o <= 1'b1; // software agreed to the shutdown
    end else if (chs_strb_i) begin
      chs_pending_o <= 1'b1;
    end
  end

endmodule

// ==== hw/button_timer.sv ====
`timescale 1ns/1ps

module button_timer import pm_pkg::*; (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic chs_button_i,
  input  logic no_power_i,
  output logic chs_strb_o,
  output logic chs_force_o
);

  localparam hold_cnt_t HOLD_SAT = hold_cnt_t'(BUTTON_HOLD + 1); // parked past the force point

  hold_cnt_t hold_cnt;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !chs_button_i) begin
      hold_cnt <= '0; // release restarts the timing
    end else if (no_power_i) begin
      // only the press matters here, a long hold must not force anything
      hold_cnt <= (hold_cnt == '0) ? hold_cnt_t'(1) : HOLD_SAT;
    end else if (hold_cnt != HOLD_SAT) begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  assign chs_strb_o  = hold_cnt == hold_cnt_t'(1);
  assign chs_force_o = hold_cnt == hold_cnt_t'(BUTTON_HOLD);

endmodule

// ==== hw/rail_sequencer.sv ====
`timescale 1ns/1ps

module rail_sequencer import pm_pkg::*; (
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  input  logic     power_up_req_i,
  output rail_en_t rail_en_o,
  output logic     up_done_o
);

  step_idx_t  step;  // number of rails currently enabled
  step_wait_t delay;
  logic       moving;

  // still work to do in the requested direction
  assign moving = power_up_req_i ? (step != step_idx_t'(NUM_RAILS)) : (step != '0);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      step  <= '0;
      delay <= '0;
    end else if (!moving) begin
      delay <= '0;
    end else if (delay == step_wait_t'(STEP_WAIT - 1)) begin
      delay <= '0;
      if (power_up_req_i) begin
        step <= step + 1'b1; // next rail on
      end else begin
        step <= step - 1'b1; // last rail off first
      end
    end else begin
      delay <= delay + 1'b1;
    end
  end

  // thermometer decode of the step index
  always_comb begin
    rail_en_o = '0;
    for (int i = 0; i < NUM_RAILS; i++) begin
      rail_en_o[i] = step > step_idx_t'(i);
    end
  end

  assign up_done_o = step == step_idx_t'(NUM_RAILS);

endmodule

// ==== hw/pm_pkg.sv ====
package pm_pkg;

  localparam int unsigned POWER_DOWN_WAIT   = 20; // cycles held in powered down
  localparam int unsigned POST_POWERUP_WAIT = 12; // settle time before the health check
  localparam int unsigned STEP_WAIT         = 4;  // cycles between rail steps
  localparam int unsigned BUTTON_HOLD       = 40; // hold length for a forced power-down
  localparam int unsigned WD_SHIFT          = 3;  // watchdog prescale bits below the conf

  typedef logic [15:0] wb_adr_t;
  typedef logic [15:0] wb_dat_t;
  typedef logic [5:0]  rail_en_t;    // ps_on, 3v3, 5v, 12v, 1v8, 1v0
  typedef logic [4:0]  power_good_t; // atx ok, aux 3v3, three mgt
  typedef logic [7:0]  health_t;
  typedef logic [2:0]  count_t;
  typedef logic [1:0]  cause_t;
  typedef logic [4:0]  wd_conf_t;

  localparam int unsigned NUM_RAILS = $bits(rail_en_t);

  typedef logic [$clog2(POWER_DOWN_WAIT+1)-1:0]   pd_wait_t;
  typedef logic [$clog2(POST_POWERUP_WAIT+1)-1:0] post_wait_t;
  typedef logic [$clog2(STEP_WAIT)-1:0]           step_wait_t;
  typedef logic [$clog2(NUM_RAILS+1)-1:0]         step_idx_t;
  typedef logic [$clog2(BUTTON_HOLD+2)-1:0]       hold_cnt_t;
  typedef logic [$bits(wd_conf_t)+WD_SHIFT-1:0]   wd_timer_t;

  localparam count_t  MAX_CRASHES      = 3'd3;
  localparam count_t  MAX_WD_OVERFLOWS = 3'd7;
  localparam health_t HEALTH_MASK      = '1; // every health input must be good

  localparam cause_t CAUSE_COLD  = 2'd0;
  localparam cause_t CAUSE_CRASH = 2'd1;
  localparam cause_t CAUSE_WD    = 2'd2;
  localparam cause_t CAUSE_USER  = 2'd3;

  localparam wb_adr_t REG_STATE     = 16'd0;
  localparam wb_adr_t REG_POWERUP   = 16'd1;
  localparam wb_adr_t REG_POWERDOWN = 16'd2;
  localparam wb_adr_t REG_CRASH     = 16'd3;
  localparam wb_adr_t REG_WD        = 16'd4;
  localparam wb_adr_t REG_CHS       = 16'd5;
  localparam wb_adr_t REG_PG        = 16'd6;
  localparam wb_adr_t REG_WD_CONF   = 16'd7;

  typedef enum logic [2:0] {
    POWERED_DOWN,
    POWERING_UP,
    CHECK,
    POWERED_UP,
    NO_POWER
  } power_state_t;

  typedef struct packed {
    power_state_t power_state;
    cause_t       no_power_cause;
    count_t       unacked_crashes;
    count_t       unacked_wd;
    logic         chs_pending;
  } pm_status_t;

  typedef struct packed {
    logic powerup;
    logic powerdown;
    logic reset;     // soft reset request, a zero written to the powerdown register
    logic crash_ack;
    logic wd_ack;
    logic chs_ack;
  } pm_cmd_t;

endpackage
